/* common/fscpu_pkg.sv */
`default_nettype none

// request side of the dispatcher, host facing
package fscpu_pkg;

	localparam int word_w      = 32;
	localparam int motor_count = 4;

	// position of the backward flag in par0
	localparam int dir_bit = 1;

	// command codes, anything not listed is an unknown request
	typedef enum logic [word_w-1:0] {
		op_motor_lp = 32'd0,	// left push
		op_motor_rp = 32'd1,	// right push
		op_motor_xa = 32'd2,	// x align
		op_motor_ya = 32'd3,	// y align
		op_exe      = 32'd30,
		op_stop     = 32'd31
	} req_op_e;

	// one host request, valid for the single cycle en is high
	typedef struct packed {
		logic              en;
		logic [word_w-1:0] cmd;
		logic [word_w-1:0] par0;	// flags
		logic [word_w-1:0] par1;	// speed
		logic [word_w-1:0] par2;	// step count
		logic [word_w-1:0] par3;	// spare
	} req_t;

endpackage

`default_nettype wire

/* common/motor_pkg.sv */
`default_nettype none

// motor side types, shared by the bank and the command units
package motor_pkg;

	localparam int speed_w = fscpu_pkg::word_w;
	localparam int step_w  = fscpu_pkg::word_w;

	// settings recorded by a motor command
	typedef struct packed {
		logic               dir;	// high runs backward
		logic [speed_w-1:0] speed;
		logic [step_w-1:0]  step;
	} motor_cfg_t;

	// everything driven toward one motor driver
	typedef struct packed {
		logic               start;
		logic               stop;
		logic [speed_w-1:0] speed;
		logic [step_w-1:0]  step;
		logic               dir;
	} motor_cmd_t;

	// command unit sequence
	typedef enum logic [1:0] {
		st_idle,
		st_start,	// start issued, waiting for busy
		st_run,
		st_done
	} unit_state_e;

endpackage

`default_nettype wire

/* logic/req_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module req_ctrl #(
	parameter int num_motors = 4
) (
	input  logic                  clk,
	input  logic                  resetn,

	input  fscpu_pkg::req_t       req,
	input  logic [num_motors-1:0] exe_done,
	output logic [num_motors-1:0] oper_bmp,
	output logic                  req_done
);

	localparam int sel_w = $clog2(num_motors);

	logic [num_motors-1:0] stage_bmp;	// motors waiting for exe
	logic [sel_w-1:0]      motor_idx;
	logic                  is_motor;
	logic                  all_done;

	// motor codes are simply 0 .. num_motors-1
	assign is_motor  = req.cmd < fscpu_pkg::word_w'(num_motors);
	assign motor_idx = req.cmd[sel_w-1:0];

	// also true with nothing running, which keeps the bitmaps clean when idle
	assign all_done = (exe_done == oper_bmp);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			stage_bmp <= '0;
			oper_bmp  <= '0;
		end else if (req.en) begin
			case (fscpu_pkg::req_op_e'(req.cmd))
			fscpu_pkg::op_exe: begin
				oper_bmp <= stage_bmp;	// stage kept until completion
			end
			fscpu_pkg::op_stop: begin
				stage_bmp <= '0;
				oper_bmp  <= '0;
			end
			default: begin
				if (is_motor)
					stage_bmp[motor_idx] <= 1'b1;
				else
					stage_bmp <= '0;	// unknown code drops the stage
			end
			endcase
		end else if (all_done) begin
			stage_bmp <= '0;
			oper_bmp  <= '0;
		end
	end

	// done level, only for a run that actually had motors in it
	always_ff @(posedge clk) begin
		if (!resetn)
			req_done <= 1'b0;
		else if (req.en)
			req_done <= 1'b0;
		else if (all_done && (|oper_bmp))
			req_done <= 1'b1;
	end

endmodule

`default_nettype wire

/* logic/param_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module param_bank #(
	parameter int num_motors = 4
) (
	input  logic                                   clk,
	input  logic                                   resetn,

	input  fscpu_pkg::req_t                        req,
	output motor_pkg::motor_cfg_t [num_motors-1:0] cfg
);

	for (genvar i = 0; i < num_motors; i++) begin : g_cfg
		logic hit;	// request addressed to this motor

		assign hit = req.en && (req.cmd == fscpu_pkg::word_w'(i));

		always_ff @(posedge clk) begin
			if (!resetn) begin
				cfg[i] <= '0;
			end else if (hit) begin
				cfg[i].dir   <= req.par0[fscpu_pkg::dir_bit];
				cfg[i].speed <= req.par1;
				cfg[i].step  <= req.par2;
			end
		end
	end

endmodule

`default_nettype wire

/* motor/motor_cmd_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module motor_cmd_unit (
	input  logic                  clk,
	input  logic                  en,

	input  motor_pkg::motor_cfg_t cfg,
	input  logic                  busy,
	output motor_pkg::motor_cmd_t cmd,
	output logic                  exe_done
);

	motor_pkg::unit_state_e state;
	motor_pkg::motor_cfg_t  run_cfg;	// settings of the run in progress
	logic                   start_q;
	logic                   stop_q;
	logic                   active;

	// states in which the motor may be moving
	assign active = (state == motor_pkg::st_start) || (state == motor_pkg::st_run);

	// en low holds the unit in reset
	always_ff @(posedge clk) begin
		if (!en) begin
			state   <= motor_pkg::st_idle;
			start_q <= 1'b0;
			stop_q  <= active;	// run cancelled, one stop pulse
		end else begin
			start_q <= 1'b0;
			stop_q  <= 1'b0;
			case (state)
			motor_pkg::st_idle: begin
				state   <= motor_pkg::st_start;
				start_q <= 1'b1;
			end
			motor_pkg::st_start: begin
				if (busy)
					state <= motor_pkg::st_run;
			end
			motor_pkg::st_run: begin
				if (!busy)
					state <= motor_pkg::st_done;	// fall of busy ends the run
			end
			default: begin
				state <= motor_pkg::st_done;	// parked until en drops
			end
			endcase
		end
	end

	// sampled on the same edge that raises start
	always_ff @(posedge clk) begin
		if (en && state == motor_pkg::st_idle)
			run_cfg <= cfg;
	end

	always_comb begin
		cmd.start = start_q;
		cmd.stop  = stop_q;
		cmd.speed = run_cfg.speed;
		cmd.step  = run_cfg.step;
		cmd.dir   = run_cfg.dir;
	end

	assign exe_done = (state == motor_pkg::st_done);

endmodule

`default_nettype wire

/* logic/fscpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module fscpu_top #(
	parameter int num_motors = fscpu_pkg::motor_count,
	parameter int speed_w    = motor_pkg::speed_w,
	parameter int step_w     = motor_pkg::step_w
) (
	input  logic                                   clk,
	input  logic                                   resetn,

	input  fscpu_pkg::req_t                        req,
	output logic                                   req_done,

	input  logic [num_motors-1:0]                  m_busy,
	output motor_pkg::motor_cmd_t [num_motors-1:0] m_cmd
);

	logic [num_motors-1:0]                  oper_bmp;
	logic [num_motors-1:0]                  exe_done;
	motor_pkg::motor_cfg_t [num_motors-1:0] cfg;

	// struct fields are sized in motor_pkg, so an override has to agree
	if (speed_w != motor_pkg::speed_w || step_w != motor_pkg::step_w) begin : g_bad_width
		$error("fscpu_top: speed_w and step_w must equal the motor_pkg widths");
	end

	// motor codes must stay clear of the exe and stop codes
	if (num_motors < 2 || num_motors > 8) begin : g_bad_count
		$error("fscpu_top: num_motors must be 2 to 8");
	end

	req_ctrl #(
		.num_motors (num_motors)
	) u_req_ctrl (
		.clk      (clk),
		.resetn   (resetn),
		.req      (req),
		.exe_done (exe_done),
		.oper_bmp (oper_bmp),
		.req_done (req_done)
	);

	param_bank #(
		.num_motors (num_motors)
	) u_param_bank (
		.clk    (clk),
		.resetn (resetn),
		.req    (req),
		.cfg    (cfg)
	);

	for (genvar i = 0; i < num_motors; i++) begin : g_motor
		// operating bit doubles as the unit's reset
		motor_cmd_unit u_motor (
			.clk      (clk),
			.en       (oper_bmp[i] & resetn),
			.cfg      (cfg[i]),
			.busy     (m_busy[i]),
			.cmd      (m_cmd[i]),
			.exe_done (exe_done[i])
		);
	end

endmodule

`default_nettype wire

/* sim/tb_clkgen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen #(
	parameter int period_ns = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

/* sim/fscpu_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module fscpu_checker #(
	parameter int num_motors = 4
) (
	input logic                                   clk,
	input logic                                   resetn,
	input logic                                   req_en,
	input logic                                   req_done,
	input logic [num_motors-1:0]                  oper_bmp,
	input motor_pkg::motor_cmd_t [num_motors-1:0] m_cmd
);

	// any request drops the done level
	a_done_clear: assert property (@(posedge clk) disable iff (!resetn) req_en |=> !req_done)
		else $error("req_done still high after a request");

	for (genvar i = 0; i < num_motors; i++) begin : g_chk
		a_start_pulse: assert property (@(posedge clk) disable iff (!resetn)
			m_cmd[i].start |=> !m_cmd[i].start)
			else $error("start of motor %0d longer than one cycle", i);

		a_start_oper: assert property (@(posedge clk) disable iff (!resetn)
			m_cmd[i].start |-> oper_bmp[i])
			else $error("start of motor %0d outside its operating set", i);
	end

endmodule

bind fscpu_top fscpu_checker #(
	.num_motors (num_motors)
) u_checker (
	.clk      (clk),
	.resetn   (resetn),
	.req_en   (req.en),
	.req_done (req_done),
	.oper_bmp (oper_bmp),
	.m_cmd    (m_cmd)
);

`default_nettype wire

/* sim/tb_fscpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_fscpu;

	localparam int num_motors = fscpu_pkg::motor_count;
	localparam int clk_period = 40;
	localparam int run_max    = 40;	// one staged run, request to done
	localparam int watchdog_cycles = (5 * run_max + 130) + 200;	// bounded waits plus fixed cycles

	logic                                   clk;
	logic                                   resetn;
	fscpu_pkg::req_t                        req;
	logic                                   req_done;
	logic [num_motors-1:0]                  m_busy;
	motor_pkg::motor_cmd_t [num_motors-1:0] m_cmd;

	logic [31:0] stim_lcg = 32'hfc36;
	logic [31:0] run_lcg  = 32'hfc36;

	// what each motor model saw
	int          start_cnt [num_motors];
	int          stop_cnt  [num_motors];
	int          fin_cnt   [num_motors];
	logic [31:0] got_speed [num_motors];
	logic [31:0] got_step  [num_motors];
	logic        got_dir   [num_motors];

	tb_clkgen #(.period_ns(clk_period)) u_clkgen (.clk(clk));

	fscpu_top #(
		.num_motors (num_motors)
	) u_dut (
		.clk      (clk),
		.resetn   (resetn),
		.req      (req),
		.req_done (req_done),
		.m_busy   (m_busy),
		.m_cmd    (m_cmd)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] rand_word();
		stim_lcg = lcg_next(stim_lcg);
		return stim_lcg;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s (time %0t)", msg, $time);
		$display("Simulation FAILED");
		$fatal(1, msg);
	endtask

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t: %s, got %0h expected %0h", $time, what, got, exp);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// motor models: busy two cycles after start, random run, dropped on stop
	initial begin : motor_model
		int phase [num_motors];
		int left  [num_motors];
		m_busy = '0;
		for (int i = 0; i < num_motors; i++) begin
			phase[i]     = 0;
			start_cnt[i] = 0;
			stop_cnt[i]  = 0;
			fin_cnt[i]   = 0;
		end
		forever begin
			@(posedge clk);
			#2;
			for (int i = 0; i < num_motors; i++) begin
				if (m_cmd[i].stop) begin
					stop_cnt[i]++;
					phase[i]  = 0;
					m_busy[i] = 1'b0;
				end else if (m_cmd[i].start) begin
					start_cnt[i]++;
					got_speed[i] = m_cmd[i].speed;
					got_step[i]  = m_cmd[i].step;
					got_dir[i]   = m_cmd[i].dir;
					left[i]  = 2;
					phase[i] = 1;
				end else if (phase[i] == 1) begin
					left[i]--;
					if (left[i] == 0) begin
						run_lcg   = lcg_next(run_lcg);
						left[i]   = 3 + int'(run_lcg % 32'd16);	// 3 to 18 cycles
						m_busy[i] = 1'b1;
						phase[i]  = 2;
					end
				end else if (phase[i] == 2) begin
					left[i]--;
					if (left[i] == 0) begin
						m_busy[i] = 1'b0;
						fin_cnt[i]++;
						phase[i] = 0;
					end
				end
			end
		end
	end

	task automatic send_req(input logic [31:0] cmd, input logic [31:0] par0,
		input logic [31:0] par1, input logic [31:0] par2);
		@(posedge clk);
		#2;
		req.en   = 1'b1;
		req.cmd  = cmd;
		req.par0 = par0;
		req.par1 = par1;
		req.par2 = par2;
		req.par3 = '0;
	endtask

	task automatic go_idle();
		@(posedge clk);
		#2;
		req = '0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic wait_done(input int max_cycles);
		int n;
		n = 0;
		while (req_done !== 1'b1) begin
			wait_cycles(1);
			n++;
			if (n > max_cycles)
				fail_now("req_done never rose after execute");
		end
	endtask

	task automatic wait_busy(input logic [num_motors-1:0] mask, input int max_cycles);
		int n;
		n = 0;
		while ((m_busy & mask) != mask) begin
			wait_cycles(1);
			n++;
			if (n > max_cycles)
				fail_now("motors never went busy after execute");
		end
	endtask

	task automatic check_start(input int i, input logic [31:0] speed, input logic [31:0] step,
		input logic dir);
		check_eq(got_speed[i], speed, $sformatf("motor %0d speed", i));
		check_eq(got_step[i], step, $sformatf("motor %0d step", i));
		check_eq(32'(got_dir[i]), 32'(dir), $sformatf("motor %0d dir", i));
	endtask

	task automatic single_motor();
		logic [31:0] par0;
		logic [31:0] speed;
		logic [31:0] step;
		int          starts;
		int          fins;
		par0   = rand_word() | 32'h2;	// backward flag
		speed  = rand_word();
		step   = rand_word();
		starts = start_cnt[2];
		fins   = fin_cnt[2];
		send_req(fscpu_pkg::op_motor_xa, par0, speed, step);
		send_req(fscpu_pkg::op_exe, 32'd0, 32'd0, 32'd0);
		go_idle();
		wait_done(run_max);
		check_eq(start_cnt[2], starts + 1, "x align start count");
		check_start(2, speed, step, par0[1]);
		check_eq(32'(got_dir[2]), 32'd1, "x align backward");
		check_eq(fin_cnt[2], fins + 1, "x align run ended before done");
		check_eq(32'(m_busy[2]), 32'd0, "x align busy at done");
		wait_cycles(2);
	endtask

	task automatic multi_motor();
		logic [31:0] par0  [num_motors];
		logic [31:0] speed [num_motors];
		logic [31:0] step  [num_motors];
		int          fins  [num_motors];
		for (int i = 0; i < num_motors; i++) begin
			par0[i]  = rand_word();
			speed[i] = rand_word();
			step[i]  = rand_word();
			fins[i]  = fin_cnt[i];
		end
		for (int i = 0; i < num_motors; i++)
			send_req(32'(i), par0[i], speed[i], step[i]);
		send_req(fscpu_pkg::op_exe, 32'd0, 32'd0, 32'd0);
		go_idle();
		wait_done(run_max);
		for (int i = 0; i < num_motors; i++) begin
			check_start(i, speed[i], step[i], par0[i][1]);
			check_eq(fin_cnt[i], fins[i] + 1, $sformatf("motor %0d not finished at done", i));
		end
		wait_cycles(2);
	endtask

	task automatic record_overwrite();
		logic [31:0] speed;
		logic [31:0] step;
		speed = rand_word();
		step  = rand_word();
		send_req(fscpu_pkg::op_motor_lp, 32'h2, rand_word(), rand_word());
		send_req(fscpu_pkg::op_motor_lp, 32'h0, speed, step);
		send_req(fscpu_pkg::op_exe, 32'd0, 32'd0, 32'd0);
		go_idle();
		wait_done(run_max);
		check_start(0, speed, step, 1'b0);
		wait_cycles(2);
	endtask

	task automatic stop_cancel();
		int stops_lp;
		int stops_rp;
		stops_lp = stop_cnt[0];
		stops_rp = stop_cnt[1];
		send_req(fscpu_pkg::op_motor_lp, rand_word(), rand_word(), rand_word());
		send_req(fscpu_pkg::op_motor_rp, rand_word(), rand_word(), rand_word());
		send_req(fscpu_pkg::op_exe, 32'd0, 32'd0, 32'd0);
		go_idle();
		wait_busy(num_motors'(3), run_max);
		send_req(fscpu_pkg::op_stop, 32'd0, 32'd0, 32'd0);
		go_idle();
		wait_cycles(3);
		check_eq(stop_cnt[0], stops_lp + 1, "left push stop pulse");
		check_eq(stop_cnt[1], stops_rp + 1, "right push stop pulse");
		wait_cycles(25);
		check_eq(32'(req_done), 32'd0, "req_done after stop");
	endtask

	task automatic empty_and_unknown();
		int starts [num_motors];
		for (int i = 0; i < num_motors; i++)
			starts[i] = start_cnt[i];
		send_req(fscpu_pkg::op_motor_ya, rand_word(), rand_word(), rand_word());
		send_req(32'd7, 32'd0, 32'd0, 32'd0);	// unknown code
		send_req(fscpu_pkg::op_exe, 32'd0, 32'd0, 32'd0);
		go_idle();
		wait_cycles(30);
		for (int i = 0; i < num_motors; i++)
			check_eq(start_cnt[i], starts[i], $sformatf("motor %0d started", i));
		check_eq(32'(req_done), 32'd0, "req_done on empty run");
	endtask

	task automatic done_clearing();
		int starts [num_motors];
		send_req(fscpu_pkg::op_motor_xa, rand_word(), rand_word(), rand_word());
		send_req(fscpu_pkg::op_exe, 32'd0, 32'd0, 32'd0);
		go_idle();
		wait_done(run_max);
		for (int i = 0; i < num_motors; i++)
			starts[i] = start_cnt[i];
		send_req(fscpu_pkg::op_exe, 32'd0, 32'd0, 32'd0);	// no restage
		go_idle();
		wait_cycles(1);
		check_eq(32'(req_done), 32'd0, "req_done after next request");
		wait_cycles(30);
		for (int i = 0; i < num_motors; i++)
			check_eq(start_cnt[i], starts[i], $sformatf("motor %0d restarted", i));
		check_eq(32'(req_done), 32'd0, "req_done after stale execute");
	endtask

	initial begin : watchdog
		#(watchdog_cycles * clk_period);
		fail_now("timeout, the tests did not finish");
	end

	initial begin
		resetn = 1'b0;
		req    = '0;
		repeat (2) @(posedge clk);
		#2;
		resetn = 1'b1;
		wait_cycles(2);
		single_motor();
		multi_motor();
		record_overwrite();
		stop_cancel();
		empty_and_unknown();
		done_clearing();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* fscpu_top.f */
common/fscpu_pkg.sv
common/motor_pkg.sv
logic/req_ctrl.sv
logic/param_bank.sv
motor/motor_cmd_unit.sv
logic/fscpu_top.sv
sim/tb_clkgen.sv
sim/fscpu_checker.sv
sim/tb_fscpu.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_fscpu
FLIST      := fscpu_top.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
